// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tbTowersGame
FILELIST = towersGame.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/gamePkg.sv
// shared types for the falling-towers object layer
// screen coordinates, fixed-point positions, colours, tower count

`default_nettype none

package gamePkg;

	// screen X or Y in whole pixels
	typedef logic [10:0] pixelCoordT;

	// position in 1/64 pixel
	// 11 integer bits over 6 fraction bits
	typedef logic [16:0] fixedPosT;

	// RGB332 pixel colour
	typedef logic [7:0] colorT;

	// active towers, 0 up to 4
	typedef logic [2:0] towerCountT;

endpackage

`default_nettype wire

// File: common/game_consts.svh
// constants for the towers game
// screen size, fixed point, object sizes, speeds, colours

`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

// visible screen
`define SCREEN_WIDTH 640
`define SCREEN_HEIGHT 480

// fraction bits of a fixed-point position
`define FIXED_SHIFT 6

// towers
`define TOWER_WIDTH 20
`define TOWER_HEIGHT 20
`define MAX_TOWERS 4
// frames between activations
`define TOWERS_WAIT 100
// in 1/64 pixel per frame
`define FALL_SPEED 100

// player block on its fixed row
`define PLAYER_WIDTH 32
`define PLAYER_HEIGHT 16
`define PLAYER_Y 440
// pixels per frame
`define PLAYER_STEP 4

// RGB332 colours
`define TOWER_COLOR 8'h5B
`define TOWER_STRIPE 8'h49
`define PLAYER_COLOR 8'h1C
`define PLAYER_EDGE 8'hFF
`define BACKGROUND_COLOR 8'h00

`endif

// File: design/drawMux.sv
// pixel priority between player and towers
// tower striping, player outline, collision pulse

`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module drawMux import gamePkg::*; (
	input wire logic clk,
	input wire logic resetN,
	input wire logic towerRequest,
	input wire logic playerRequest,
	input wire pixelCoordT towerOffsetY,
	input wire pixelCoordT playerOffsetX,
	output colorT rgb,
	output logic collision
);

	localparam pixelCoordT LAST_COLUMN = pixelCoordT'(`PLAYER_WIDTH - 1);

	colorT nextRgb;

	// player drawn over towers
	always_comb begin
		if (playerRequest) begin
			// outline on the first and last column
			if (playerOffsetX == '0 || playerOffsetX == LAST_COLUMN) begin
				nextRgb = `PLAYER_EDGE;
			end else begin
				nextRgb = `PLAYER_COLOR;
			end
		end else if (towerRequest) begin
			// stripes of 4 rows
			nextRgb = towerOffsetY[2] ? `TOWER_STRIPE : `TOWER_COLOR;
		end else begin
			nextRgb = `BACKGROUND_COLOR;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			rgb <= `BACKGROUND_COLOR;
			collision <= 1'b0;
		end else begin
			rgb <= nextRgb;
			// one pulse per overlapping pixel
			collision <= towerRequest && playerRequest;
		end
	end

	// overlap pixels are always shown with the player on top
	collisionShowsPlayer: assert property (@(posedge clk) disable iff (!resetN)
		collision |-> (rgb == `PLAYER_COLOR) || (rgb == `PLAYER_EDGE));

endmodule

`default_nettype wire

// File: design/playerSprite.sv
// player block on a fixed row
// per-frame step with clamping, registered hit test with offsets

`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module playerSprite import gamePkg::*; (
	input wire logic clk,
	input wire logic resetN,
	input wire logic startOfFrame,
	input wire logic pause,
	input wire logic moveLeft,
	input wire logic moveRight,
	input wire pixelCoordT pixelX,
	input wire pixelCoordT pixelY,
	output logic playerRequest,
	output pixelCoordT playerOffsetX,
	output pixelCoordT playerOffsetY
);

	localparam pixelCoordT START_X = pixelCoordT'(288);
	localparam pixelCoordT MAX_X = pixelCoordT'(`SCREEN_WIDTH - `PLAYER_WIDTH);
	localparam pixelCoordT STEP = pixelCoordT'(`PLAYER_STEP);
	localparam pixelCoordT ROW_TOP = pixelCoordT'(`PLAYER_Y);
	localparam pixelCoordT ROW_BOTTOM = pixelCoordT'(`PLAYER_Y + `PLAYER_HEIGHT);

	pixelCoordT playerX;
	logic hit;

	// step once per frame, left wins over right
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			playerX <= START_X;
		end else if (startOfFrame && !pause) begin
			if (moveLeft) begin
				playerX <= (playerX < STEP) ? '0 : playerX - STEP;
			end else if (moveRight) begin
				playerX <= (playerX > MAX_X - STEP) ? MAX_X : playerX + STEP;
			end
		end
	end

	// half-open box around the player
	assign hit = (pixelX >= playerX) &&
		({1'b0, pixelX} < {1'b0, playerX} + 12'(`PLAYER_WIDTH)) &&
		(pixelY >= ROW_TOP) && (pixelY < ROW_BOTTOM);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			playerRequest <= 1'b0;
			playerOffsetX <= '0;
			playerOffsetY <= '0;
		end else begin
			playerRequest <= hit;
			// offsets only meaningful on a hit
			playerOffsetX <= hit ? pixelX - playerX : '0;
			playerOffsetY <= hit ? pixelY - ROW_TOP : '0;
		end
	end

	// clamping keeps the whole block on screen
	playerOnScreen: assert property (@(posedge clk) disable iff (!resetN)
		playerX <= MAX_X);

endmodule

`default_nettype wire

// File: design/towersGame.sv
// top of the object layer
// towers and player side by side, merged by the draw mux
// two cycles from pixel to colour and collision

`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module towersGame import gamePkg::*; #(
	parameter int towersWait = `TOWERS_WAIT
) (
	input wire logic clk,
	input wire logic resetN,
	input wire logic startOfFrame,
	input wire logic pause,
	input wire logic moveLeft,
	input wire logic moveRight,
	input wire pixelCoordT pixelX,
	input wire pixelCoordT pixelY,
	input wire pixelCoordT spawnX,
	output colorT rgb,
	output logic collision
);

	logic towerRequest;
	pixelCoordT towerOffsetY;
	logic playerRequest;
	pixelCoordT playerOffsetX;

	towerField #(
		.towersWait(towersWait)
	) i_towerField (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.pause(pause),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.spawnX(spawnX),
		.towerRequest(towerRequest),
		.towerOffsetX(),
		.towerOffsetY(towerOffsetY)
	);

	playerSprite i_playerSprite (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.pause(pause),
		.moveLeft(moveLeft),
		.moveRight(moveRight),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.playerRequest(playerRequest),
		.playerOffsetX(playerOffsetX),
		.playerOffsetY()
	);

	// only the offsets that shape the colour go on
	drawMux i_drawMux (
		.clk(clk),
		.resetN(resetN),
		.towerRequest(towerRequest),
		.playerRequest(playerRequest),
		.towerOffsetY(towerOffsetY),
		.playerOffsetX(playerOffsetX),
		.rgb(rgb),
		.collision(collision)
	);

endmodule

`default_nettype wire

// File: test/tbTowersGame.sv
// testbench for the towers game object layer
// clock, reset, frame stimulus, reference model of towers and player
// two-cycle expected pipeline checked by concurrent assertions, timeout

`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module tbTowersGame import gamePkg::*; ();

	localparam int TB_WAIT = 3;
	localparam int RESET_CYCLES = 8;
	// cycles in one frame with sof, 4 towers of 13 probes, player, random and flush
	localparam int FRAME_CYCLES = 64;
	localparam int TOTAL_FRAMES = 1 + 10 + 320 + 240 + 640;
	localparam int TIMEOUT_CYCLES = 2 * (TOTAL_FRAMES * FRAME_CYCLES + RESET_CYCLES);

	logic clk = 1'b0;
	logic resetN;
	logic startOfFrame;
	logic pause;
	logic moveLeft;
	logic moveRight;
	pixelCoordT pixelX;
	pixelCoordT pixelY;
	pixelCoordT spawnX;
	colorT rgb;
	logic collision;

	// reference model state
	int mTowerX [`MAX_TOWERS];
	int mTowerY [`MAX_TOWERS];
	int mCount;
	int mTimer;
	int mPlayerX;
	int respawns = 0;
	int collisionProbes = 0;

	// levels for the next driven cycle
	int nextSpawn = 0;
	logic nextPause = 1'b0;
	logic nextLeft = 1'b0;
	logic nextRight = 1'b0;

	int seed = 45;
	int errorCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int cycleCount = 0;

	// expectation travels two stages like the DUT
	colorT expRgbNow = `BACKGROUND_COLOR;
	colorT expRgb1 = `BACKGROUND_COLOR;
	colorT expRgb2 = `BACKGROUND_COLOR;
	logic expColNow = 1'b0;
	logic expCol1 = 1'b0;
	logic expCol2 = 1'b0;
	logic expValidNow = 1'b0;
	logic expValid1 = 1'b0;
	logic expValid2 = 1'b0;

	towersGame #(
		.towersWait(TB_WAIT)
	) i_towersGame (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.pause(pause),
		.moveLeft(moveLeft),
		.moveRight(moveRight),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.spawnX(spawnX),
		.rgb(rgb),
		.collision(collision)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		expRgb1 <= expRgbNow;
		expRgb2 <= expRgb1;
		expCol1 <= expColNow;
		expCol2 <= expCol1;
		expValid1 <= expValidNow;
		expValid2 <= expValid1;
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycleCount);
			$display("Simulation FAILED");
			$finish;
		end
	end

	rgbMatchesModel: assert property (@(posedge clk) disable iff (!resetN)
		expValid2 |-> rgb == expRgb2)
	else begin
		errorCount++;
		$display("ERROR at %0t ns: rgb expected %02h, got %02h",
			$time, $sampled(expRgb2), $sampled(rgb));
	end

	collisionMatchesModel: assert property (@(posedge clk) disable iff (!resetN)
		expValid2 |-> collision == expCol2)
	else begin
		errorCount++;
		$display("ERROR at %0t ns: collision expected %0b, got %0b",
			$time, $sampled(expCol2), $sampled(collision));
	end

	function automatic int randomBelow(input int limit);
		return int'($unsigned($random(seed)) % limit);
	endfunction

	// colour and overlap of one pixel from the model state
	task automatic predictPixel(input int px, input int py, output colorT c, output logic col);
		logic towerHit;
		logic playerHit;
		int tx;
		int ty;
		int offY;
		int offX;
		towerHit = 1'b0;
		offY = 0;
		for (int i = 0; i < mCount; i++) begin
			tx = mTowerX[i] / 64;
			ty = mTowerY[i] / 64;
			if (!towerHit && px >= tx && px < tx + `TOWER_WIDTH &&
			    py >= ty && py < ty + `TOWER_HEIGHT) begin
				towerHit = 1'b1;
				offY = py - ty;
			end
		end
		offX = px - mPlayerX;
		playerHit = px >= mPlayerX && px < mPlayerX + `PLAYER_WIDTH &&
			py >= `PLAYER_Y && py < `PLAYER_Y + `PLAYER_HEIGHT;
		if (playerHit) begin
			c = (offX == 0 || offX == `PLAYER_WIDTH - 1) ? `PLAYER_EDGE : `PLAYER_COLOR;
		end else if (towerHit) begin
			c = ((offY / 4) % 2 == 1) ? `TOWER_STRIPE : `TOWER_COLOR;
		end else begin
			c = `BACKGROUND_COLOR;
		end
		col = playerHit && towerHit;
	endtask

	// once-per-frame model step with the timer first
	task automatic advanceFrame();
		int oldCount;
		oldCount = mCount;
		if (mTimer == 0) begin
			mTimer = TB_WAIT;
			if (mCount < `MAX_TOWERS) begin
				mTowerX[mCount] = nextSpawn * 64;
				mTowerY[mCount] = 0;
				mCount++;
			end
		end else begin
			mTimer--;
		end
		for (int i = 0; i < oldCount; i++) begin
			if (!nextPause) begin
				if (mTowerY[i] > `SCREEN_HEIGHT * 64) begin
					mTowerY[i] = 0;
					mTowerX[i] = nextSpawn * 64;
					respawns++;
				end else begin
					mTowerY[i] = mTowerY[i] + `FALL_SPEED;
				end
			end
		end
		if (!nextPause) begin
			if (nextLeft) begin
				mPlayerX = (mPlayerX < `PLAYER_STEP) ? 0 : mPlayerX - `PLAYER_STEP;
			end else if (nextRight) begin
				mPlayerX = (mPlayerX + `PLAYER_STEP > `SCREEN_WIDTH - `PLAYER_WIDTH) ?
					`SCREEN_WIDTH - `PLAYER_WIDTH : mPlayerX + `PLAYER_STEP;
			end
		end
	endtask

	// one pixel per cycle with its expectation alongside
	task automatic driveCycle(input logic sof, input int x, input int y);
		pixelCoordT px;
		pixelCoordT py;
		colorT c;
		logic col;
		px = pixelCoordT'(x);
		py = pixelCoordT'(y);
		@(posedge clk);
		predictPixel(int'(px), int'(py), c, col);
		startOfFrame <= sof;
		pixelX <= px;
		pixelY <= py;
		spawnX <= pixelCoordT'(nextSpawn);
		pause <= nextPause;
		moveLeft <= nextLeft;
		moveRight <= nextRight;
		expRgbNow <= c;
		expColNow <= col;
		expValidNow <= 1'b1;
		if (col) begin
			collisionProbes++;
		end
		if (sof) begin
			advanceFrame();
		end
	endtask

	// leading rows of each tower, a column through it, player edges, some random pixels
	task automatic probeObjects();
		int tx;
		int ty;
		for (int i = 0; i < mCount; i++) begin
			tx = mTowerX[i] / 64;
			ty = mTowerY[i] / 64;
			for (int r = 0; r < 8; r++) begin
				driveCycle(1'b0, tx, ty + r);
			end
			for (int r = 0; r < `TOWER_HEIGHT; r += 4) begin
				driveCycle(1'b0, tx + 12, ty + r);
			end
		end
		driveCycle(1'b0, mPlayerX, `PLAYER_Y);
		driveCycle(1'b0, mPlayerX + `PLAYER_WIDTH - 1, `PLAYER_Y + 3);
		driveCycle(1'b0, mPlayerX + 1, `PLAYER_Y + `PLAYER_HEIGHT - 1);
		driveCycle(1'b0, mPlayerX + 16, `PLAYER_Y + 8);
		driveCycle(1'b0, mPlayerX - 1, `PLAYER_Y + 8);
		driveCycle(1'b0, mPlayerX + `PLAYER_WIDTH, `PLAYER_Y + 8);
		for (int k = 0; k < 3; k++) begin
			driveCycle(1'b0, randomBelow(`SCREEN_WIDTH), randomBelow(`SCREEN_HEIGHT));
		end
		driveCycle(1'b0, `SCREEN_WIDTH - 1, `SCREEN_HEIGHT - 1);
		driveCycle(1'b0, `SCREEN_WIDTH - 1, `SCREEN_HEIGHT - 1);
	endtask

	task automatic runFrame();
		driveCycle(1'b1, randomBelow(`SCREEN_WIDTH), randomBelow(`SCREEN_HEIGHT));
		probeObjects();
	endtask

	// report once the last pixels have left the pipeline and been checked
	task automatic finishTest(input string name, input int startErrors);
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (errorCount == startErrors) begin
			testsPassed++;
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", name, errorCount - startErrors);
		end
	endtask

	initial begin
		int startErrors;
		resetN = 1'b0;
		startOfFrame = 1'b0;
		pause = 1'b0;
		moveLeft = 1'b0;
		moveRight = 1'b0;
		// parked outside every object
		pixelX = pixelCoordT'(`SCREEN_WIDTH - 1);
		pixelY = pixelCoordT'(`SCREEN_HEIGHT - 1);
		spawnX = '0;
		for (int i = 0; i < `MAX_TOWERS; i++) begin
			mTowerX[i] = 0;
			mTowerY[i] = 0;
		end
		mCount = 1;
		mTimer = TB_WAIT;
		mPlayerX = 288;
		repeat (RESET_CYCLES) @(posedge clk);
		resetN <= 1'b1;
		@(negedge clk);

		startErrors = errorCount;
		assert (rgb == `BACKGROUND_COLOR && collision == 1'b0)
		else begin
			errorCount++;
			$display("ERROR at %0t ns: after reset rgb is %02h and collision is %0b",
				$time, rgb, collision);
		end
		nextSpawn = randomBelow(620);
		probeObjects();
		finishTest("after reset", startErrors);

		startErrors = errorCount;
		for (int f = 0; f < 6; f++) begin
			nextSpawn = randomBelow(620);
			runFrame();
		end
		nextPause = 1'b1;
		for (int f = 0; f < 4; f++) begin
			nextSpawn = randomBelow(620);
			runFrame();
		end
		nextPause = 1'b0;
		finishTest("falling and pause", startErrors);

		startErrors = errorCount;
		for (int f = 0; f < 320; f++) begin
			nextSpawn = randomBelow(620);
			runFrame();
		end
		assert (mCount == `MAX_TOWERS && respawns > 0)
		else begin
			errorCount++;
			$display("activation or respawn was never reached in the run");
		end
		finishTest("activation and respawn", startErrors);

		startErrors = errorCount;
		nextLeft = 1'b1;
		for (int f = 0; f < 80; f++) begin
			nextSpawn = randomBelow(620);
			runFrame();
		end
		nextLeft = 1'b0;
		nextRight = 1'b1;
		for (int f = 0; f < 160; f++) begin
			nextSpawn = randomBelow(620);
			runFrame();
		end
		nextRight = 1'b0;
		finishTest("player stepping and clamping", startErrors);

		// towers respawn just left of the parked player and fall through its row
		startErrors = errorCount;
		collisionProbes = 0;
		nextSpawn = 596;
		for (int f = 0; f < 640; f++) begin
			runFrame();
		end
		assert (collisionProbes > 0)
		else begin
			errorCount++;
			$display("no overlapping pixel of tower and player was reached");
		end
		finishTest("priority and collision", startErrors);

		$display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
		if (testsFailed == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: towerField/towerField.sv
// falling towers in fixed point
// activation timer, per-frame fall and respawn
// registered per-pixel hit test with offsets, lowest index first

`timescale 1ns/1ps
`default_nettype none

`include "game_consts.svh"

module towerField import gamePkg::*; #(
	parameter int towersWait = `TOWERS_WAIT
) (
	input wire logic clk,
	input wire logic resetN,
	input wire logic startOfFrame,
	input wire logic pause,
	input wire pixelCoordT pixelX,
	input wire pixelCoordT pixelY,
	input wire pixelCoordT spawnX,
	output logic towerRequest,
	output pixelCoordT towerOffsetX,
	output pixelCoordT towerOffsetY
);

	// wide enough to hold towersWait, also when it is 0
	localparam int TIMER_BITS = $clog2(towersWait + 2);
	// bottom limit, past it a tower respawns
	localparam fixedPosT BOTTOM_FIXED = fixedPosT'(`SCREEN_HEIGHT << `FIXED_SHIFT);

	fixedPosT towerPosX [`MAX_TOWERS];
	fixedPosT towerPosY [`MAX_TOWERS];
	towerCountT towerCount;
	logic [TIMER_BITS-1:0] towerTimer;

	// whole-pixel top-left corners
	pixelCoordT towerLeft [`MAX_TOWERS];
	pixelCoordT towerTop [`MAX_TOWERS];

	logic hitFound;
	pixelCoordT hitOffsetX;
	pixelCoordT hitOffsetY;

	always_comb begin
		for (int i = 0; i < `MAX_TOWERS; i++) begin
			towerLeft[i] = pixelCoordT'(towerPosX[i] >> `FIXED_SHIFT);
			towerTop[i] = pixelCoordT'(towerPosY[i] >> `FIXED_SHIFT);
		end
	end

	// frame update: timer, activation, fall, respawn
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			towerTimer <= TIMER_BITS'(towersWait);
			// one tower waiting at the top-left corner
			towerCount <= towerCountT'(1);
			for (int i = 0; i < `MAX_TOWERS; i++) begin
				towerPosX[i] <= '0;
				towerPosY[i] <= '0;
			end
		end else if (startOfFrame) begin
			// timer keeps running during pause
			if (towerTimer == '0) begin
				towerTimer <= TIMER_BITS'(towersWait);
				if (towerCount < towerCountT'(`MAX_TOWERS)) begin
					towerCount <= towerCount + 1'b1;
				end
			end else begin
				towerTimer <= towerTimer - 1'b1;
			end
			for (int i = 0; i < `MAX_TOWERS; i++) begin
				if (towerCountT'(i) < towerCount) begin
					// already active, falls unless paused
					if (!pause) begin
						if (towerPosY[i] > BOTTOM_FIXED) begin
							towerPosY[i] <= '0;
							towerPosX[i] <= fixedPosT'(spawnX) << `FIXED_SHIFT;
						end else begin
							towerPosY[i] <= towerPosY[i] + fixedPosT'(`FALL_SPEED);
						end
					end
				end else if (towerCountT'(i) == towerCount && towerTimer == '0) begin
					// newly activated slot enters at the top
					towerPosY[i] <= '0;
					towerPosX[i] <= fixedPosT'(spawnX) << `FIXED_SHIFT;
				end
			end
		end
	end

	// first hit among active towers
	// walk downward so the lowest index is written last
	always_comb begin
		hitFound = 1'b0;
		hitOffsetX = '0;
		hitOffsetY = '0;
		for (int i = `MAX_TOWERS - 1; i >= 0; i--) begin
			if ((towerCountT'(i) < towerCount) &&
			    (pixelX >= towerLeft[i]) &&
			    ({1'b0, pixelX} < {1'b0, towerLeft[i]} + 12'(`TOWER_WIDTH)) &&
			    (pixelY >= towerTop[i]) &&
			    ({1'b0, pixelY} < {1'b0, towerTop[i]} + 12'(`TOWER_HEIGHT))) begin
				hitFound = 1'b1;
				hitOffsetX = pixelX - towerLeft[i];
				hitOffsetY = pixelY - towerTop[i];
			end
		end
	end

	// one cycle behind the pixel
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			towerRequest <= 1'b0;
			towerOffsetX <= '0;
			towerOffsetY <= '0;
		end else begin
			towerRequest <= hitFound;
			towerOffsetX <= hitOffsetX;
			towerOffsetY <= hitOffsetY;
		end
	end

	// activation stops at the last slot
	activeCountBound: assert property (@(posedge clk) disable iff (!resetN)
		towerCount <= towerCountT'(`MAX_TOWERS));

	// a request always points inside some tower
	offsetInsideTower: assert property (@(posedge clk) disable iff (!resetN)
		towerRequest |-> (towerOffsetX < pixelCoordT'(`TOWER_WIDTH)) &&
			(towerOffsetY < pixelCoordT'(`TOWER_HEIGHT)));

endmodule

`default_nettype wire

// File: towersGame.f
+incdir+common
common/gamePkg.sv
towerField/towerField.sv
design/playerSprite.sv
design/drawMux.sv
design/towersGame.sv
test/tbTowersGame.sv
